// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_fds_disk
FILELIST  ?= verilog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/fds_block_tracker.sv ====
// Block tracker that finds where each disk block ends and gates head movement on CPU reads
`timescale 1ns/100ps
`default_nettype none

module fds_block_tracker (
	input  logic           clk,
	input  logic           diskreset,
	input  logic           ce,
	input  logic           transfer_start,
	input  logic           byte_ready,
	input  logic           disk_read,
	input  logic           read_done,
	input  fds_pkg::byte_t prg_dbus,
	output logic           head_advance
);
	import fds_pkg::*;

	block_type_t block_type;
	logic [15:0] file_size;
	logic [15:0] byte_cnt;   // Index within current block
	logic        new_byte;   // Byte pending under the head
	logic        block_end;
	logic        last_byte;

	assign head_advance = ce & read_done & new_byte & ~block_end;

	// The image omits CRCs, so block ends come from type and length
	always_comb begin
		case (block_type)
			BLK_DISK_INFO:   last_byte = (byte_cnt == DISK_INFO_LAST);
			BLK_FILE_AMOUNT: last_byte = (byte_cnt == FILE_AMOUNT_LAST);
			BLK_FILE_HEADER: last_byte = (byte_cnt == FILE_HEADER_LAST);
			BLK_FILE_DATA:   last_byte = (byte_cnt == file_size);
			default:         last_byte = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			block_type <= BLK_NONE;
			file_size <= 16'd0;
			byte_cnt <= 16'd0;
			new_byte <= 1'b0;
			block_end <= 1'b0;
		end else if (ce) begin
			if (disk_read) begin
				if (byte_cnt == 16'd0) begin
					block_type <= block_type_t'(prg_dbus[2:0]);
				end
				if (block_type == BLK_FILE_HEADER) begin
					if (byte_cnt == FILE_SIZE_LO_IDX) file_size[7:0] <= prg_dbus;
					if (byte_cnt == FILE_SIZE_HI_IDX) file_size[15:8] <= prg_dbus;
				end
			end

			if (read_done && new_byte) begin
				new_byte <= 1'b0;
				byte_cnt <= byte_cnt + 16'd1;
				if (last_byte) begin
					block_end <= 1'b1;
				end
			end

			if (transfer_start) begin  // Next block begins
				block_type <= BLK_NONE;
				byte_cnt <= 16'd0;
				new_byte <= 1'b0;
				block_end <= 1'b0;
			end

			if (byte_ready) new_byte <= 1'b1;  // Fresh byte wins over a clear
		end
	end

	// One advance per byte delivered by the drive
	a_advance_needs_byte: assert property (@(posedge clk) disable iff (diskreset)
		head_advance && !byte_ready |=> !head_advance)
		else $error("head advanced twice for one byte");

endmodule

`default_nettype wire

// ==== hw/fds_cpu_port.sv ====
// CPU side of the FDS disk logic: registers, timer IRQ, status reads and PRG address map
`timescale 1ns/100ps
`default_nettype none

module fds_cpu_port (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  logic               prg_read,
	input  logic               prg_write,
	input  logic               byte_ready,
	input  logic               disk_end,
	input  logic               pre_gap_done,
	input  fds_pkg::cpu_addr_t prg_ain,
	input  fds_pkg::byte_t     prg_din,
	input  fds_pkg::disk_pos_t disk_pos,
	output logic               motor_on,
	output logic               rewind,
	output logic               transfer_on,
	output logic               transfer_start,
	output logic               disk_read,
	output logic               read_done,
	output fds_pkg::byte_t     prg_dout,
	output logic               prg_bus_write,
	output logic               prg_allow,
	output logic               irq,
	output fds_pkg::prg_addr_t prg_aout
);
	import fds_pkg::*;

	logic [15:0]   timer_latch;
	logic [15:0]   timer;
	logic          timer_irq;
	logic          timer_en;
	logic          timer_repeat;
	logic          disk_reg_en;   // $4023 bit 0
	logic          disk_irq_en;
	logic          byte_flag;
	logic          read_4030;
	logic          read_4031;
	side_t         side;
	image_offset_t side_offset;
	image_offset_t rom_offset;
	logic          is_disk_addr;
	logic          prg_is_ram;
	logic [5:0]    prg_bank;
	logic          disk_ready;

	assign is_disk_addr = (prg_ain == REG_DISK_READ);
	assign disk_read = ce & prg_read & is_disk_addr;
	assign read_done = ce & read_4031;
	assign transfer_start = ce & prg_write & (prg_ain == REG_DISK_CTRL) & prg_din[6] & ~transfer_on;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			timer_latch <= 16'd0;
			timer <= 16'd0;
			timer_irq <= 1'b0;
			timer_en <= 1'b0;
			timer_repeat <= 1'b0;
			disk_reg_en <= 1'b0;
			disk_irq_en <= 1'b0;
			motor_on <= 1'b0;
			rewind <= 1'b0;
			transfer_on <= 1'b0;
			byte_flag <= 1'b0;
			read_4030 <= 1'b0;
			read_4031 <= 1'b0;
			side <= '0;
		end else if (ce) begin
			if (timer_en) begin
				if (timer == 16'd0) begin
					timer_irq <= 1'b1;
					timer <= timer_latch;
					if (!timer_repeat) timer_en <= 1'b0;  // One-shot
				end else begin
					timer <= timer - 16'd1;
				end
			end

			if (prg_write) begin
				case (prg_ain)
					REG_TIMER_LO: timer_latch[7:0] <= prg_din;
					REG_TIMER_HI: timer_latch[15:8] <= prg_din;
					REG_TIMER_CTRL: begin
						timer_repeat <= prg_din[0];
						timer_en <= prg_din[1] & disk_reg_en;
						if (prg_din[1] && disk_reg_en) begin
							timer <= timer_latch;
						end else begin
							timer_irq <= 1'b0;
						end
					end
					REG_IO_ENABLE: begin
						disk_reg_en <= prg_din[0];
						if (!prg_din[0]) begin
							timer_en <= 1'b0;
							timer_irq <= 1'b0;
						end
					end
					REG_DISK_CTRL: begin
						motor_on <= prg_din[0];
						rewind <= prg_din[1];
						transfer_on <= prg_din[6];
						disk_irq_en <= prg_din[7];
						if (transfer_start) byte_flag <= 1'b0;
					end
					REG_DISK_SIDE: side <= prg_din[1:0];
					default: ;
				endcase
			end

			// Status read acknowledges both IRQ sources on the next ce
			read_4030 <= prg_read & (prg_ain == REG_STATUS);
			if (read_4030) begin
				timer_irq <= 1'b0;
				byte_flag <= 1'b0;
			end

			read_4031 <= prg_read & is_disk_addr;
			if (read_4031) byte_flag <= 1'b0;

			if (byte_ready) byte_flag <= 1'b1;
		end
	end

	assign disk_ready = motor_on & ~rewind & pre_gap_done & ~disk_end;

	always_comb begin
		prg_bus_write = 1'b1;
		case (prg_ain)
			REG_STATUS:       prg_dout = {byte_flag, disk_end, 5'd0, timer_irq};
			REG_DRIVE_STATUS: prg_dout = {4'h4, 2'b00, ~disk_ready, 1'b0};  // Disk always inserted
			REG_EXT_INPUT:    prg_dout = 8'b1000_0000;                       // Battery good
			default: begin
				prg_dout = 8'd0;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	assign irq = timer_irq | (byte_flag & disk_irq_en);

	// 16 + 65500 * side
	assign side_offset = image_offset_t'(IMAGE_HEADER_BYTES)
		+ image_offset_t'(SIDE_BYTES) * image_offset_t'(side);
	assign rom_offset = side_offset + image_offset_t'(disk_pos);

	// $6000-$DFFF work RAM, $E000 and up BIOS at bank 0
	assign prg_is_ram = prg_ain[15] ^ (&prg_ain[14:13]);
	assign prg_bank = prg_is_ram ? {WRAM_BANK_PREFIX, prg_ain[14:13]} : 6'd0;
	assign prg_aout = is_disk_addr ? {IMAGE_BANK, rom_offset} : {3'b000, prg_bank, prg_ain[12:0]};
	assign prg_allow = ((prg_ain[15] | is_disk_addr) & ~prg_write) | prg_is_ram;

	a_start_is_pulse: assert property (@(posedge clk) disable iff (diskreset)
		transfer_start |=> !transfer_start)
		else $error("transfer_start held for two cycles");

endmodule

`default_nettype wire

// ==== hw/fds_disk_drive.sv ====
// Disk drive model that times the pre-gap and each byte under the head and tracks head position
`timescale 1ns/100ps
`default_nettype none

module fds_disk_drive #(
	parameter logic [19:0] PRE_GAP_DELAY = 20'd65535,
	parameter logic [19:0] BYTE_DELAY    = 20'd99
) (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  logic               motor_on,
	input  logic               rewind,
	input  logic               transfer_on,
	input  logic               transfer_start,
	input  logic               head_advance,
	output logic               byte_ready,
	output logic               pre_gap_done,
	output logic               disk_end,
	output fds_pkg::disk_pos_t disk_pos
);
	import fds_pkg::*;

	localparam disk_pos_t LAST_POS = disk_pos_t'(SIDE_BYTES - 1);

	logic [19:0] transfer_cnt;  // ce pulses since last event
	logic        spinning;
	logic        byte_slot;

	assign spinning = motor_on & ~rewind;
	assign byte_slot = spinning & pre_gap_done & ~transfer_start & (transfer_cnt == BYTE_DELAY);

	// Byte passes the head, only seen while a transfer is on
	assign byte_ready = ce & byte_slot & transfer_on;

	assign disk_end = (disk_pos == LAST_POS);

	always_ff @(posedge clk) begin
		if (diskreset) begin
			transfer_cnt <= 20'd0;
			pre_gap_done <= 1'b0;
		end else if (ce) begin
			if (!motor_on) begin
				transfer_cnt <= 20'd0;  // Motor stopped
			end else if (rewind) begin
				transfer_cnt <= 20'd0;
				pre_gap_done <= 1'b0;
			end else if (!pre_gap_done) begin
				if (transfer_cnt == PRE_GAP_DELAY) begin
					pre_gap_done <= 1'b1;  // Head reached the first block
					transfer_cnt <= 20'd0;
				end else begin
					transfer_cnt <= transfer_cnt + 20'd1;
				end
			end else if (transfer_start) begin
				transfer_cnt <= 20'd0;  // Realign byte timing to the new transfer
			end else if (byte_slot) begin
				transfer_cnt <= 20'd0;
			end else begin
				transfer_cnt <= transfer_cnt + 20'd1;
			end
		end
	end

	// Head position
	always_ff @(posedge clk) begin
		if (diskreset) begin
			disk_pos <= '0;
		end else if (ce) begin
			if (rewind) begin
				disk_pos <= '0;
			end else if (head_advance && !disk_end) begin
				disk_pos <= disk_pos + disk_pos_t'(1);
			end
		end
	end

	a_pos_in_side: assert property (@(posedge clk) disable iff (diskreset)
		disk_pos <= LAST_POS)
		else $error("head position past end of side");

endmodule

`default_nettype wire

// ==== hw/fds_disk_top.sv ====
// Top level of the FDS disk logic; joins drive, block tracker and CPU port and sets drive timing
`timescale 1ns/100ps
`default_nettype none

module fds_disk_top #(
	parameter logic [19:0] PRE_GAP_DELAY = 20'd65535,  // Shortened from about 525k CPU cycles
	parameter logic [19:0] BYTE_DELAY    = 20'd99      // Original drive needs 149
) (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  fds_pkg::cpu_addr_t prg_ain,
	input  logic               prg_read,
	input  logic               prg_write,
	input  fds_pkg::byte_t     prg_din,
	input  fds_pkg::byte_t     prg_dbus,
	output fds_pkg::byte_t     prg_dout,
	output logic               prg_bus_write,
	output fds_pkg::prg_addr_t prg_aout,
	output logic               prg_allow,
	output logic               irq
);
	import fds_pkg::*;

	logic      motor_on;
	logic      rewind;
	logic      transfer_on;
	logic      transfer_start;
	logic      byte_ready;
	logic      pre_gap_done;
	logic      disk_end;
	disk_pos_t disk_pos;
	logic      disk_read;
	logic      read_done;
	logic      head_advance;

	fds_disk_drive #(
		.PRE_GAP_DELAY (PRE_GAP_DELAY),
		.BYTE_DELAY    (BYTE_DELAY)
	) u_drive (
		.clk            (clk),
		.diskreset      (diskreset),
		.ce             (ce),
		.motor_on       (motor_on),
		.rewind         (rewind),
		.transfer_on    (transfer_on),
		.transfer_start (transfer_start),
		.head_advance   (head_advance),
		.byte_ready     (byte_ready),
		.pre_gap_done   (pre_gap_done),
		.disk_end       (disk_end),
		.disk_pos       (disk_pos)
	);

	fds_block_tracker u_tracker (
		.clk            (clk),
		.diskreset      (diskreset),
		.ce             (ce),
		.transfer_start (transfer_start),
		.byte_ready     (byte_ready),
		.disk_read      (disk_read),
		.read_done      (read_done),
		.prg_dbus       (prg_dbus),
		.head_advance   (head_advance)
	);

	fds_cpu_port u_cpu_port (
		.clk            (clk),
		.diskreset      (diskreset),
		.ce             (ce),
		.prg_read       (prg_read),
		.prg_write      (prg_write),
		.byte_ready     (byte_ready),
		.disk_end       (disk_end),
		.pre_gap_done   (pre_gap_done),
		.prg_ain        (prg_ain),
		.prg_din        (prg_din),
		.disk_pos       (disk_pos),
		.motor_on       (motor_on),
		.rewind         (rewind),
		.transfer_on    (transfer_on),
		.transfer_start (transfer_start),
		.disk_read      (disk_read),
		.read_done      (read_done),
		.prg_dout       (prg_dout),
		.prg_bus_write  (prg_bus_write),
		.prg_allow      (prg_allow),
		.irq            (irq),
		.prg_aout       (prg_aout)
	);

endmodule

`default_nettype wire

// ==== hw/fds_pkg.sv ====
// Types, register map and disk image layout shared by the FDS disk RTL; imported by each module
`default_nettype none

package fds_pkg;

	typedef logic [7:0]  byte_t;          // CPU data bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [21:0] prg_addr_t;      // Cartridge memory address
	typedef logic [15:0] disk_pos_t;      // Head position within one side
	typedef logic [17:0] image_offset_t;  // Byte offset into the .fds image
	typedef logic [1:0]  side_t;

	// First byte of every block on the disk
	typedef enum logic [2:0] {
		BLK_NONE        = 3'd0,
		BLK_DISK_INFO   = 3'd1,
		BLK_FILE_AMOUNT = 3'd2,
		BLK_FILE_HEADER = 3'd3,
		BLK_FILE_DATA   = 3'd4
	} block_type_t;

	localparam cpu_addr_t REG_TIMER_LO     = 16'h4020;
	localparam cpu_addr_t REG_TIMER_HI     = 16'h4021;
	localparam cpu_addr_t REG_TIMER_CTRL   = 16'h4022;
	localparam cpu_addr_t REG_IO_ENABLE    = 16'h4023;
	localparam cpu_addr_t REG_DISK_CTRL    = 16'h4025;
	localparam cpu_addr_t REG_DISK_SIDE    = 16'h4027;
	localparam cpu_addr_t REG_STATUS       = 16'h4030;
	localparam cpu_addr_t REG_DISK_READ    = 16'h4031;
	localparam cpu_addr_t REG_DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t REG_EXT_INPUT    = 16'h4033;

	// Image layout, CRC bytes are not stored in the file
	localparam int SIDE_BYTES         = 65500;
	localparam int IMAGE_HEADER_BYTES = 16;

	localparam logic [3:0] IMAGE_BANK       = 4'b1111;  // Image at PRG $3C0000 and up
	localparam logic [3:0] WRAM_BANK_PREFIX = 4'b0001;  // Work RAM at PRG $08000

	// Last byte index of the fixed-length blocks
	localparam logic [15:0] DISK_INFO_LAST   = 16'h0037;
	localparam logic [15:0] FILE_AMOUNT_LAST = 16'h0001;
	localparam logic [15:0] FILE_HEADER_LAST = 16'h000F;

	// File size inside the file header
	localparam logic [15:0] FILE_SIZE_LO_IDX = 16'h000D;
	localparam logic [15:0] FILE_SIZE_HI_IDX = 16'h000E;

endpackage

`default_nettype wire

// ==== verification/tb_clock.sv ====
// Testbench clock and reset source; drives clk at a 100 ns period and holds diskreset for 4 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 50
) (
	output logic clk,
	output logic diskreset
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		diskreset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		diskreset = 1'b0;  // Released on a falling edge like other inputs
	end

endmodule

`default_nettype wire

// ==== verification/tb_fds_disk.sv ====
// Random-stimulus testbench for fds_disk_top; models the disk image, timer and head position
`timescale 1ns/100ps
`default_nettype none

module tb_fds_disk;
	import fds_pkg::*;

	localparam logic [19:0] PRE_GAP = 20'd40;
	localparam logic [19:0] BYTE_DLY = 20'd9;
	localparam int TIMER_MAX = 40;
	localparam int MAX_READS = 70;
	// ce comes every second clock
	localparam int CYCLE_LIMIT = 2 * (2 * MAX_READS * (int'(BYTE_DLY) + 1) + int'(PRE_GAP) + 1
		+ 8 * (TIMER_MAX + 3)) + 2000;

	logic        clk;
	logic        diskreset;
	logic        ce;
	logic [15:0] prg_ain;
	logic        prg_read;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [7:0]  prg_dbus;
	logic [7:0]  prg_dout;
	logic        prg_bus_write;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic        irq;

	logic [7:0]  disk_image [0:255];  // First bytes of every side
	logic [7:0]  last_dout;
	logic [21:0] last_aout;
	logic [21:0] read_aout;           // Address of the latest $4031 read
	logic        last_bw;
	logic        last_allow;
	logic        irq_after;
	int          cycle_count = 0;
	int          model_pos;
	int          model_side;
	int          blk_idx;
	int          blk_last;
	logic [2:0]  blk_type;
	logic [15:0] model_file_size;
	bit          blk_ended;

	tb_clock clock_gen (.clk(clk), .diskreset(diskreset));

	fds_disk_top #(.PRE_GAP_DELAY(PRE_GAP), .BYTE_DELAY(BYTE_DLY)) DUT (
		.clk(clk), .diskreset(diskreset), .ce(ce), .prg_ain(prg_ain), .prg_read(prg_read),
		.prg_write(prg_write), .prg_din(prg_din), .prg_dbus(prg_dbus), .prg_dout(prg_dout),
		.prg_bus_write(prg_bus_write), .prg_aout(prg_aout), .prg_allow(prg_allow), .irq(irq)
	);

	// Image offset 16 + 65500 * side + pos, fill pattern elsewhere
	function automatic logic [7:0] image_byte(input logic [21:0] a);
		int off;
		int idx;
		off = int'(a[17:0]);
		if (a[21:18] == 4'hF && off >= 16) begin
			idx = (off - 16) % 65500;
			if (idx < 256) return disk_image[idx];
		end
		return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]};
	endfunction

	assign prg_dbus = image_byte(prg_aout);

	function automatic logic [21:0] disk_addr(input int side, input int pos);
		return 22'h3C0000 + 22'(16 + 65500 * side + pos);
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic give_up(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "stopped");
	endtask

	// One ce with a bus access, then one clock without ce
	task automatic bus_cycle(input logic [15:0] addr, input logic rd, input logic wr,
			input logic [7:0] din);
		@(negedge clk);
		prg_ain = addr;
		prg_read = rd;
		prg_write = wr;
		prg_din = din;
		ce = 1'b1;
		#10;
		last_dout = prg_dout;
		last_aout = prg_aout;
		last_bw = prg_bus_write;
		last_allow = prg_allow;
		@(negedge clk);
		irq_after = irq;  // State after the ce edge
		ce = 1'b0;
		prg_read = 1'b0;
		prg_write = 1'b0;
		prg_ain = 16'h0000;
	endtask

	task automatic tick();
		bus_cycle(16'h0000, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic timer_test(input bit rep);
		int n;
		n = $urandom_range(TIMER_MAX, 3);
		bus_cycle(REG_IO_ENABLE, 1'b0, 1'b1, 8'h01);
		bus_cycle(REG_TIMER_LO, 1'b0, 1'b1, 8'(n));
		bus_cycle(REG_TIMER_HI, 1'b0, 1'b1, 8'h00);
		bus_cycle(REG_TIMER_CTRL, 1'b0, 1'b1, {6'd0, 1'b1, rep});
		for (int k = 1; k <= n + 1; k++) begin
			tick();
			check("timer irq rise", 32'(k == n + 1), 32'(irq_after));
		end
		bus_cycle(REG_STATUS, 1'b1, 1'b0, 8'h00);
		check("timer status bit", 32'd1, 32'(last_dout[0]));
		tick();
		check("timer irq clear", 32'd0, 32'(irq_after));
		if (rep) begin
			for (int k = 3; k <= n + 1; k++) begin
				tick();
				check("timer repeat irq", 32'(k == n + 1), 32'(irq_after));
			end
		end else begin
			repeat (n + 2) begin
				tick();
				check("one-shot stays low", 32'd0, 32'(irq_after));
			end
		end
		bus_cycle(REG_IO_ENABLE, 1'b0, 1'b1, 8'h00);
		check("timer off", 32'd0, 32'(irq_after));
	endtask

	task automatic wait_byte();
		int polls;
		polls = 0;
		forever begin
			bus_cycle(REG_STATUS, 1'b1, 1'b0, 8'h00);
			check("status drives bus", 32'd1, 32'(last_bw));
			if (last_dout[7]) break;
			polls++;
			if (polls > 4 * (int'(BYTE_DLY) + 1)) give_up("byte flag never set during transfer");
		end
	endtask

	task automatic read_one();
		logic [7:0] b;
		wait_byte();
		bus_cycle(REG_DISK_READ, 1'b1, 1'b0, 8'h00);
		read_aout = last_aout;
		check("disk read address", 32'(disk_addr(model_side, model_pos)), 32'(read_aout));
		tick();  // Byte flag clears on the ce after the read
		b = disk_image[model_pos];
		if (blk_idx == 0) blk_type = b[2:0];
		if (blk_type == 3'd3 && blk_idx == 13) model_file_size[7:0] = b;
		if (blk_type == 3'd3 && blk_idx == 14) model_file_size[15:8] = b;
		case (blk_type)
			3'd1: blk_last = 16'h37;
			3'd2: blk_last = 1;
			3'd3: blk_last = 15;
			default: blk_last = int'(model_file_size);
		endcase
		if (!blk_ended) begin
			model_pos++;
			if (blk_idx == blk_last) blk_ended = 1'b1;
		end
		blk_idx++;
	endtask

	task automatic read_block();
		bus_cycle(REG_DISK_CTRL, 1'b0, 1'b1, 8'h01);
		bus_cycle(REG_DISK_CTRL, 1'b0, 1'b1, 8'h41);  // Transfer start
		blk_idx = 0;
		blk_ended = 1'b0;
		while (!blk_ended) read_one();
		repeat (2) read_one();  // Head must hold at the block end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d clock cycles", cycle_count);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int size;
		logic [15:0] addr;
		int polls;
		void'($urandom(32'hd7eb));
		ce = 1'b0;
		prg_ain = 16'h0000;
		prg_read = 1'b0;
		prg_write = 1'b0;
		prg_din = 8'h00;
		for (int i = 0; i < 256; i++) disk_image[i] = 8'($urandom);
		size = $urandom_range(20, 1);
		disk_image[0] = 8'h02;   // File amount
		disk_image[2] = 8'h03;   // File header, size at 13 and 14
		disk_image[15] = 8'(size);
		disk_image[16] = 8'h00;
		disk_image[18] = 8'h04;  // File data
		@(negedge diskreset);

		// Reset state
		check("irq after reset", 32'd0, 32'(irq));
		repeat (8) begin
			if ($urandom_range(1, 0) == 1) addr = 16'($urandom_range(16'h3FFF, 0));
			else addr = 16'($urandom_range(16'hDFFF, 16'h6000));
			bus_cycle(addr, 1'b0, 1'b0, 8'h00);
			check("bus write outside registers", 32'd0, 32'(last_bw));
		end

		timer_test(1'b0);
		timer_test(1'b1);

		// Disk read
		bus_cycle(REG_DISK_CTRL, 1'b0, 1'b1, 8'h01);
		polls = 0;
		do begin
			bus_cycle(REG_DRIVE_STATUS, 1'b1, 1'b0, 8'h00);
			polls++;
			if (polls > int'(PRE_GAP) + 10) give_up("drive never became ready after pre-gap");
		end while (last_dout[1]);
		model_pos = 0;
		model_side = 0;
		model_file_size = 16'h0000;
		read_block();
		check("file amount end", 32'(disk_addr(0, 2)), 32'(read_aout));
		read_block();
		read_block();
		check("file data end", 32'(disk_addr(0, 19 + size)), 32'(read_aout));

		// Side and memory map
		model_side = $urandom_range(3, 1);
		bus_cycle(REG_DISK_SIDE, 1'b0, 1'b1, 8'(model_side));
		bus_cycle(REG_DISK_READ, 1'b1, 1'b0, 8'h00);
		check("side address", 32'(disk_addr(model_side, model_pos)), 32'(last_aout));
		repeat (6) begin
			addr = 16'($urandom_range(16'hDFFF, 16'h6000));
			bus_cycle(addr, 1'b1, 1'b0, 8'h00);
			check("work ram address", 32'({3'b000, 4'b0001, addr[14:13], addr[12:0]}),
				32'(last_aout));
			check("work ram allow", 32'd1, 32'(last_allow));
			addr = 16'($urandom_range(16'hFFFF, 16'hE000));
			bus_cycle(addr, 1'b1, 1'b0, 8'h00);
			check("bios address", 32'({9'd0, addr[12:0]}), 32'(last_aout));
		end

		// Disk IRQ, first drop any byte left from earlier
		bus_cycle(REG_DISK_CTRL, 1'b0, 1'b1, 8'hC1);
		polls = 0;
		do begin
			bus_cycle(REG_DISK_READ, 1'b1, 1'b0, 8'h00);
			tick();
			polls++;
			if (polls > 4) give_up("disk read never cleared the byte flag");
		end while (irq_after);
		polls = 0;
		while (!irq_after) begin
			tick();
			polls++;
			if (polls > 4 * (int'(BYTE_DLY) + 1)) give_up("disk irq never rose");
		end
		bus_cycle(REG_DISK_READ, 1'b1, 1'b0, 8'h00);
		tick();
		check("disk irq clear", 32'd0, 32'(irq_after));
		bus_cycle(REG_DISK_CTRL, 1'b0, 1'b1, 8'h41);
		repeat (3 * (int'(BYTE_DLY) + 1)) begin
			tick();
			check("disk irq disabled", 32'd0, 32'(irq_after));
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/fds_pkg.sv
hw/fds_disk_drive.sv
hw/fds_block_tracker.sv
hw/fds_cpu_port.sv
hw/fds_disk_top.sv
verification/tb_clock.sv
verification/tb_fds_disk.sv
